// File: common/ext_mem_pkg.sv
package ext_mem_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Cache geometry
   localparam int BYTE_OFF_W = 2;
   localparam int WORD_OFF_W = 2;
   localparam int LINE_OFF_W = 4;
   localparam int TAG_W      = ADDR_W - LINE_OFF_W - WORD_OFF_W - BYTE_OFF_W;

   // Words per line and lines per cache
   localparam int N_WORDS = 1 << WORD_OFF_W;
   localparam int N_LINES = 1 << LINE_OFF_W;

   // Low bit of each address field
   // Byte in word sits at bit 0
   localparam int WORD_LSB = BYTE_OFF_W;
   localparam int LINE_LSB = WORD_LSB + WORD_OFF_W;
   localparam int TAG_LSB  = LINE_LSB + LINE_OFF_W;

   // Byte address, front end and back end alike
   typedef logic [ADDR_W-1:0] addr_t;

   // One bus word
   typedef logic [DATA_W-1:0] data_t;

   // Byte enables, all zero for a read
   typedef logic [STRB_W-1:0] strb_t;

   // Upper address bits kept per line
   typedef logic [TAG_W-1:0] tag_t;

endpackage

// File: cache/l1_cache.sv
module l1_cache (
   input  logic               clk,
   input  logic               rst,

   // Processor side
   input  logic               valid,
   input  ext_mem_pkg::addr_t addr,
   input  ext_mem_pkg::data_t wdata,
   input  ext_mem_pkg::strb_t wstrb,
   output ext_mem_pkg::data_t rdata,
   output logic               ready,

   // Memory side
   output logic               mem_valid,
   output ext_mem_pkg::addr_t mem_addr,
   output ext_mem_pkg::data_t mem_wdata,
   output ext_mem_pkg::strb_t mem_wstrb,
   input  ext_mem_pkg::data_t mem_rdata,
   input  logic               mem_ready
);

   // Idle also serves hits
   typedef enum logic [1:0] {
      st_idle,
      st_refill,
      st_write
   } state_t;

   state_t state;

   // Per line valid flags
   logic [ext_mem_pkg::N_LINES-1:0] line_vld;

   // Tag store, one entry per line
   ext_mem_pkg::tag_t tag_mem [ext_mem_pkg::N_LINES];

   // Data store indexed by {line, word}
   ext_mem_pkg::data_t data_mem [ext_mem_pkg::N_LINES*ext_mem_pkg::N_WORDS];

   // Word being fetched during refill
   logic [ext_mem_pkg::WORD_OFF_W-1:0] fill_cnt;

   // Fields of the pending request
   ext_mem_pkg::tag_t                  req_tag;
   logic [ext_mem_pkg::LINE_OFF_W-1:0] req_line;
   logic [ext_mem_pkg::WORD_OFF_W-1:0] req_word;

   // Word offset placed on the memory bus
   logic [ext_mem_pkg::WORD_OFF_W-1:0] be_word;

   logic               hit;
   logic               is_write;
   logic               req_new;
   logic               fill_last;
   ext_mem_pkg::data_t merged;

   // Address split
   assign req_tag  = addr[ext_mem_pkg::TAG_LSB +: ext_mem_pkg::TAG_W];
   assign req_line = addr[ext_mem_pkg::LINE_LSB +: ext_mem_pkg::LINE_OFF_W];
   assign req_word = addr[ext_mem_pkg::WORD_LSB +: ext_mem_pkg::WORD_OFF_W];

   // Tag compare against the indexed line
   assign hit = line_vld[req_line] && (tag_mem[req_line] == req_tag);

   assign is_write = |wstrb;

   // Valid is still high while ready pulses, so skip that cycle
   assign req_new = valid && !ready;

   assign fill_last = (fill_cnt == '1);

   // Stored word with the strobed bytes replaced
   always_comb begin
      merged = data_mem[{req_line, req_word}];
      for (int b = 0; b < ext_mem_pkg::STRB_W; b++) begin
         if (wstrb[b]) begin
            merged[8*b +: 8] = wdata[8*b +: 8];
         end
      end
   end

   // Back-end request
   assign mem_valid = (state == st_refill) || (state == st_write);

   // Refill walks the line, write-through uses the request word
   assign be_word = (state == st_write) ? req_word : fill_cnt;

   // Always word aligned
   assign mem_addr = {req_tag, req_line, be_word, {ext_mem_pkg::BYTE_OFF_W{1'b0}}};

   assign mem_wdata = wdata;

   // Refill reads carry no strobes
   assign mem_wstrb = (state == st_write) ? wstrb : '0;

   // Control FSM
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= st_idle;
         ready    <= 1'b0;
         fill_cnt <= '0;
         line_vld <= '0;
      end else begin
         // Single cycle pulse
         ready <= 1'b0;
         case (state)
            st_idle: begin
               if (req_new) begin
                  if (is_write) begin
                     state <= st_write;
                  end else if (hit) begin
                     ready <= 1'b1;
                  end else begin
                     // Line is stale until the last word lands
                     line_vld[req_line] <= 1'b0;
                     state              <= st_refill;
                  end
               end
            end
            st_refill: begin
               if (mem_ready) begin
                  // Wraps back to zero after the last word
                  fill_cnt <= fill_cnt + 1'b1;
                  if (fill_last) begin
                     line_vld[req_line] <= 1'b1;
                     // Request now hits in idle
                     state <= st_idle;
                  end
               end
            end
            st_write: begin
               if (mem_ready) begin
                  ready <= 1'b1;
                  state <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Storage and read data
   always_ff @(posedge clk) begin
      // Read hit data for the ready cycle
      if (state == st_idle && req_new && !is_write && hit) begin
         rdata <= data_mem[{req_line, req_word}];
      end

      // Refill words land as they return
      if (state == st_refill && mem_ready) begin
         data_mem[{req_line, fill_cnt}] <= mem_rdata;
         if (fill_last) begin
            tag_mem[req_line] <= req_tag;
         end
      end

      // Write hit updates alongside the memory write
      // Rewriting the same bytes while waiting is harmless
      if (state == st_write && hit) begin
         data_mem[{req_line, req_word}] <= merged;
      end
   end

endmodule

// File: hdl/bus_merge.sv
module bus_merge (
   input  logic               clk,
   input  logic               rst,

   // Master 0, data cache
   input  logic               m0_valid,
   input  ext_mem_pkg::addr_t m0_addr,
   input  ext_mem_pkg::data_t m0_wdata,
   input  ext_mem_pkg::strb_t m0_wstrb,
   output ext_mem_pkg::data_t m0_rdata,
   output logic               m0_ready,

   // Master 1, instruction cache
   input  logic               m1_valid,
   input  ext_mem_pkg::addr_t m1_addr,
   input  ext_mem_pkg::data_t m1_wdata,
   input  ext_mem_pkg::strb_t m1_wstrb,
   output ext_mem_pkg::data_t m1_rdata,
   output logic               m1_ready,

   // Slave, external memory
   output logic               s_valid,
   output ext_mem_pkg::addr_t s_addr,
   output ext_mem_pkg::data_t s_wdata,
   output ext_mem_pkg::strb_t s_wstrb,
   input  ext_mem_pkg::data_t s_rdata,
   input  logic               s_ready
);

   // One hot grant, bit 0 for master 0
   // Zero means no transfer is locked
   logic [1:0] gnt_q;

   // Grant in effect this cycle
   logic [1:0] sel;

   // Locked grant wins, else fixed priority to master 0
   always_comb begin
      if (gnt_q != 2'b00) begin
         sel = gnt_q;
      end else if (m0_valid) begin
         sel = 2'b01;
      end else if (m1_valid) begin
         sel = 2'b10;
      end else begin
         sel = 2'b00;
      end
   end

   // Request steering
   assign s_valid = (sel[0] && m0_valid) || (sel[1] && m1_valid);
   assign s_addr  = sel[1] ? m1_addr : m0_addr;
   assign s_wdata = sel[1] ? m1_wdata : m0_wdata;
   assign s_wstrb = sel[1] ? m1_wstrb : m0_wstrb;

   // Read data is shared, ready tells whose it is
   assign m0_rdata = s_rdata;
   assign m1_rdata = s_rdata;

   // Ready only to the granted master
   assign m0_ready = sel[0] && s_ready;
   assign m1_ready = sel[1] && s_ready;

   // Grant lock
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         gnt_q <= 2'b00;
      end else if (s_ready) begin
         // Transfer done, arbitrate again next cycle
         gnt_q <= 2'b00;
      end else if (gnt_q == 2'b00 && s_valid) begin
         gnt_q <= sel;
      end
   end

endmodule

// File: hdl/ext_mem.sv
module ext_mem (
   input  logic               clk,
   input  logic               rst,

   // Instruction bus
   input  logic               i_valid,
   input  ext_mem_pkg::addr_t i_addr,
   input  ext_mem_pkg::data_t i_wdata,
   input  ext_mem_pkg::strb_t i_wstrb,
   output ext_mem_pkg::data_t i_rdata,
   output logic               i_ready,

   // Data bus
   input  logic               d_valid,
   input  ext_mem_pkg::addr_t d_addr,
   input  ext_mem_pkg::data_t d_wdata,
   input  ext_mem_pkg::strb_t d_wstrb,
   output ext_mem_pkg::data_t d_rdata,
   output logic               d_ready,

   // External memory
   output logic               mem_valid,
   output ext_mem_pkg::addr_t mem_addr,
   output ext_mem_pkg::data_t mem_wdata,
   output ext_mem_pkg::strb_t mem_wstrb,
   input  ext_mem_pkg::data_t mem_rdata,
   input  logic               mem_ready
);

   // Instruction cache back end
   logic               ic_valid;
   ext_mem_pkg::addr_t ic_addr;
   ext_mem_pkg::data_t ic_wdata;
   ext_mem_pkg::strb_t ic_wstrb;
   ext_mem_pkg::data_t ic_rdata;
   logic               ic_ready;

   // Data cache back end
   logic               dc_valid;
   ext_mem_pkg::addr_t dc_addr;
   ext_mem_pkg::data_t dc_wdata;
   ext_mem_pkg::strb_t dc_wstrb;
   ext_mem_pkg::data_t dc_rdata;
   logic               dc_ready;

   // Same cache as the data side, write strobes stay zero
   l1_cache u_icache (
      .clk       (clk),
      .rst       (rst),
      .valid     (i_valid),
      .addr      (i_addr),
      .wdata     (i_wdata),
      .wstrb     (i_wstrb),
      .rdata     (i_rdata),
      .ready     (i_ready),
      .mem_valid (ic_valid),
      .mem_addr  (ic_addr),
      .mem_wdata (ic_wdata),
      .mem_wstrb (ic_wstrb),
      .mem_rdata (ic_rdata),
      .mem_ready (ic_ready)
   );

   l1_cache u_dcache (
      .clk       (clk),
      .rst       (rst),
      .valid     (d_valid),
      .addr      (d_addr),
      .wdata     (d_wdata),
      .wstrb     (d_wstrb),
      .rdata     (d_rdata),
      .ready     (d_ready),
      .mem_valid (dc_valid),
      .mem_addr  (dc_addr),
      .mem_wdata (dc_wdata),
      .mem_wstrb (dc_wstrb),
      .mem_rdata (dc_rdata),
      .mem_ready (dc_ready)
   );

   // Data side is master 0 and wins ties
   bus_merge u_merge (
      .clk      (clk),
      .rst      (rst),
      .m0_valid (dc_valid),
      .m0_addr  (dc_addr),
      .m0_wdata (dc_wdata),
      .m0_wstrb (dc_wstrb),
      .m0_rdata (dc_rdata),
      .m0_ready (dc_ready),
      .m1_valid (ic_valid),
      .m1_addr  (ic_addr),
      .m1_wdata (ic_wdata),
      .m1_wstrb (ic_wstrb),
      .m1_rdata (ic_rdata),
      .m1_ready (ic_ready),
      .s_valid  (mem_valid),
      .s_addr   (mem_addr),
      .s_wdata  (mem_wdata),
      .s_wstrb  (mem_wstrb),
      .s_rdata  (mem_rdata),
      .s_ready  (mem_ready)
   );

endmodule

// File: test/tb_clock.sv
module tb_clock (
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 1ps;

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Rising edge on rst so the async reset fires
   initial begin
      rst = 1'b0;
      #1;
      rst = 1'b1;
      // Held over five rising clock edges
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
   end

endmodule

// File: test/mem_model.sv
module mem_model #(
   parameter ext_mem_pkg::data_t INIT_MULT = 32'd1
) (
   input  logic               clk,
   input  logic               rst,
   // Extra wait states while high
   input  logic               stall,
   input  logic               mem_valid,
   input  ext_mem_pkg::addr_t mem_addr,
   input  ext_mem_pkg::data_t mem_wdata,
   input  ext_mem_pkg::strb_t mem_wstrb,
   output ext_mem_pkg::data_t mem_rdata,
   output logic               mem_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   // Written words only, keyed by word address
   ext_mem_pkg::data_t mem [ext_mem_pkg::addr_t];

   ext_mem_pkg::addr_t word;
   ext_mem_pkg::data_t upd;

   assign word = mem_addr >> ext_mem_pkg::BYTE_OFF_W;

   // Words never written hold w times INIT_MULT
   function automatic ext_mem_pkg::data_t stored(input ext_mem_pkg::addr_t w);
      if (mem.exists(w)) begin
         return mem[w];
      end
      return ext_mem_pkg::data_t'(w) * INIT_MULT;
   endfunction

   // Ack at least one cycle after the request, skip the ready cycle itself
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_ready <= 1'b0;
      end else begin
         mem_ready <= 1'b0;
         if (mem_valid && !mem_ready && !stall) begin
            mem_ready <= 1'b1;
            mem_rdata <= stored(word);
            upd = stored(word);
            for (int b = 0; b < ext_mem_pkg::STRB_W; b++) begin
               if (mem_wstrb[b]) begin
                  upd[8*b +: 8] = mem_wdata[8*b +: 8];
               end
            end
            // Reads leave the store alone
            if (mem_wstrb != '0) begin
               mem[word] = upd;
            end
         end
      end
   end

endmodule

// File: test/ext_mem_assert.sv
module ext_mem_assert (
   input logic               clk,
   input logic               rst,
   input logic               i_valid,
   input logic               i_ready,
   input logic               d_valid,
   input logic               d_ready,
   input logic               mem_valid,
   input logic               mem_ready,
   input ext_mem_pkg::addr_t mem_addr
);
   timeunit 1ns;
   timeprecision 1ps;

   // External request stays put until acknowledged
   hold_req: assert property (@(posedge clk) disable iff (rst)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
      else $error("external request dropped or changed before mem_ready");

   // Ready only answers a request
   i_ready_req: assert property (@(posedge clk) disable iff (rst)
      $rose(i_ready) |-> $past(i_valid))
      else $error("i_ready rose without i_valid");

   d_ready_req: assert property (@(posedge clk) disable iff (rst)
      $rose(d_ready) |-> $past(d_valid))
      else $error("d_ready rose without d_valid");

   // Quiet outputs during reset
   reset_quiet: assert property (@(posedge clk)
      rst |-> !i_ready && !d_ready && !mem_valid)
      else $error("ready or mem_valid high during reset");

endmodule

bind ext_mem ext_mem_assert u_assert (.*);

// File: test/ext_mem_tb.sv
module ext_mem_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // Fill pattern multiplier, odd so every word differs
   localparam ext_mem_pkg::data_t INIT_MULT = 32'h9E37_79B1;
   localparam int READY_TIMEOUT = 500;
   localparam int RESET_TIMEOUT = 50;
   localparam int N_OPS = 200;

   logic clk;
   logic rst;
   logic stall;

   logic               i_valid;
   ext_mem_pkg::addr_t i_addr;
   ext_mem_pkg::data_t i_wdata;
   ext_mem_pkg::strb_t i_wstrb;
   ext_mem_pkg::data_t i_rdata;
   logic               i_ready;

   logic               d_valid;
   ext_mem_pkg::addr_t d_addr;
   ext_mem_pkg::data_t d_wdata;
   ext_mem_pkg::strb_t d_wstrb;
   ext_mem_pkg::data_t d_rdata;
   logic               d_ready;

   logic               mem_valid;
   ext_mem_pkg::addr_t mem_addr;
   ext_mem_pkg::data_t mem_wdata;
   ext_mem_pkg::strb_t mem_wstrb;
   ext_mem_pkg::data_t mem_rdata;
   logic               mem_ready;

   // Reference memory, written words keyed by word address
   ext_mem_pkg::data_t model_mem [ext_mem_pkg::addr_t];

   // x^16 + x^14 + x^13 + x^11 + 1
   logic [15:0] lfsr_q = 16'd6;

   tb_clock u_clock (.*);

   ext_mem u_ext_mem (.*);

   mem_model #(.INIT_MULT(INIT_MULT)) u_mem (.*);

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // Fill pattern overlaid by data writes
   function automatic ext_mem_pkg::data_t expected_word(input ext_mem_pkg::addr_t a);
      ext_mem_pkg::addr_t w;
      w = a >> 2;
      if (model_mem.exists(w)) begin
         return model_mem[w];
      end
      return ext_mem_pkg::data_t'(w) * INIT_MULT;
   endfunction

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare_word(input string bus, input ext_mem_pkg::addr_t a,
                               input ext_mem_pkg::data_t exp, input ext_mem_pkg::data_t act);
      if (act !== exp) begin
         $display("MISMATCH %0t %s bus addr %h expected %h actual %h",
                  $time, bus, a, exp, act);
         abort_run();
      end
   endtask

   task automatic verify_latency(input string bus, input ext_mem_pkg::addr_t a,
                                 input int exp, input int act);
      if (act != exp) begin
         $display("MISMATCH %0t %s bus addr %h hit latency expected %0d actual %0d",
                  $time, bus, a, exp, act);
         abort_run();
      end
   endtask

   task automatic expect_low(input string sig, input logic act);
      if (act !== 1'b0) begin
         $display("MISMATCH %0t %s expected 0 actual %b", $time, sig, act);
         abort_run();
      end
   endtask

   // One transfer, cycles counts edges from valid to ready
   task automatic bus_access(input logic side, input ext_mem_pkg::addr_t a,
                             input ext_mem_pkg::data_t wd, input ext_mem_pkg::strb_t st,
                             output ext_mem_pkg::data_t rd, output int cycles);
      logic done;
      done = 1'b0;
      cycles = 0;
      @(posedge clk);
      #1;
      if (side) begin
         d_valid = 1'b1;
         d_addr  = a;
         d_wdata = wd;
         d_wstrb = st;
      end else begin
         i_valid = 1'b1;
         i_addr  = a;
         i_wdata = wd;
         i_wstrb = st;
      end
      while (!done) begin
         @(posedge clk);
         #1;
         cycles++;
         done = side ? d_ready : i_ready;
         if (!done && cycles >= READY_TIMEOUT) begin
            $display("Timeout: %s bus gave no ready for address %h",
                     side ? "data" : "instruction", a);
            abort_run();
         end
      end
      // Still inside the ready cycle
      rd = side ? d_rdata : i_rdata;
      if (side) begin
         d_valid = 1'b0;
      end else begin
         i_valid = 1'b0;
      end
   endtask

   // Random traffic on one bus, side 1 is the data bus
   task automatic run_side(input logic side);
      string              bus;
      logic [31:0]        r;
      ext_mem_pkg::addr_t base;
      ext_mem_pkg::addr_t a;
      ext_mem_pkg::data_t wd;
      ext_mem_pkg::strb_t st;
      ext_mem_pkg::data_t rd;
      ext_mem_pkg::data_t nxt;
      int                 cyc;
      if (side) begin
         bus  = "data";
         base = 16'h8000;
      end else begin
         bus  = "instruction";
         base = 16'h0000;
      end
      for (int k = 0; k < N_OPS; k++) begin
         // 1 KB window, four tags per line index
         r = rand_bits(8);
         a = base | {6'd0, r[7:0], 2'b00};
         r = rand_bits(1);
         st = (side && r[0]) ? ext_mem_pkg::strb_t'(rand_bits(4)) : '0;
         wd = rand_bits(32);
         if (st != '0) begin
            bus_access(side, a, wd, st, rd, cyc);
            nxt = expected_word(a);
            for (int b = 0; b < ext_mem_pkg::STRB_W; b++) begin
               if (st[b]) begin
                  nxt[8*b +: 8] = wd[8*b +: 8];
               end
            end
            model_mem[a >> 2] = nxt;
         end else begin
            bus_access(side, a, '0, '0, rd, cyc);
            compare_word(bus, a, expected_word(a), rd);
            // Line just returned, so any word in it hits
            r = rand_bits(2);
            a = {a[15:4], r[1:0], 2'b00};
            bus_access(side, a, '0, '0, rd, cyc);
            verify_latency(bus, a, 1, cyc);
            compare_word(bus, a, expected_word(a), rd);
         end
      end
   endtask

   // Random memory stalls, about one cycle in four
   initial begin
      logic [31:0] r;
      stall = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (!rst) begin
            r = rand_bits(2);
            stall = (r[1:0] == 2'b11);
         end
      end
   end

   initial begin
      int   cnt;
      logic in_reset;
      i_valid = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_wstrb = '0;
      d_valid = 1'b0;
      d_addr  = '0;
      d_wdata = '0;
      d_wstrb = '0;
      cnt = 0;
      in_reset = 1'b1;
      while (in_reset) begin
         @(posedge clk);
         cnt++;
         in_reset = rst;
         if (in_reset && cnt > RESET_TIMEOUT) begin
            $display("Timeout: reset was never released");
            abort_run();
         end
      end
      // Idle bus after reset
      repeat (4) begin
         @(posedge clk);
         #1;
         expect_low("i_ready", i_ready);
         expect_low("d_ready", d_ready);
         expect_low("mem_valid", mem_valid);
      end
      // Both buses at once share the external port
      fork
         run_side(1'b1);
         run_side(1'b0);
      join
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: filelist.f
common/ext_mem_pkg.sv
cache/l1_cache.sv
hdl/bus_merge.sv
hdl/ext_mem.sv
test/tb_clock.sv
test/mem_model.sv
test/ext_mem_assert.sv
test/ext_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ext_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module ext_mem_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vext_mem_tb)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
echo "Pass message not found"
exit 1
